// File: logic/isa_pkg.sv
package isa_pkg;

    // Address and data width of the core
    localparam int XLEN = 32;

    // Compressed instructions and instruction halves are both one parcel wide
    localparam int PARCEL_W = 16;

    // Length of an instruction, decided by its first parcel
    typedef enum logic {
        ILEN_16,
        ILEN_32
    } ilen_e;

    // Both low bits set open a 32-bit instruction
    // Every other pattern is a complete compressed instruction
    function automatic ilen_e parcel_len(input logic [PARCEL_W-1:0] parcel);
        ilen_e len;
        if (parcel[1:0] == 2'b11) begin
            len = ILEN_32;
        end else begin
            len = ILEN_16;
        end
        return len;
    endfunction

endpackage

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // Word request toward the instruction memory, always 4-byte aligned
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] addr;
    } imem_req_t;

    // One returned instruction word, responses come back in request order
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] data;
    } imem_rsp_t;

    // Restart request from execute
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] pc;    // Target pc, bit 0 is ignored
    } redirect_t;

    // Instruction handed to decode
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] bits;  // Upper half zero when compressed
        logic [isa_pkg::XLEN-1:0] pc;
        isa_pkg::ilen_e           len;
    } instr_t;

    // Aligner FSM
    // EMPTY waits for a word with nothing held
    // HALF keeps one parcel from the previous word
    // DRAIN throws away responses to requests from before a redirect
    typedef enum logic [1:0] {
        ALIGN_EMPTY,
        ALIGN_HALF,
        ALIGN_DRAIN
    } align_state_e;

endpackage

// File: logic/fetch_req_gen.sv
`timescale 1ns/1ps

module fetch_req_gen (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  logic                 redirect_valid_i,
    input  fetch_pkg::redirect_t redirect_i,

    input  logic                 req_credit_i,     // Aligner has room for one more response
    output logic                 req_fire_o,

    output logic                 imem_req_valid_o,
    input  logic                 imem_req_ready_i,
    output fetch_pkg::imem_req_t imem_req_o
);

    localparam int XLEN = isa_pkg::XLEN;

    logic            armed_q;   // Set by the first redirect after reset
    logic            pend_q;    // A request is on the bus and not yet taken
    logic [XLEN-1:0] addr_q;

    // No request goes out in the redirect cycle itself.
    // A presented request stays up until the memory takes it
    assign imem_req_valid_o = armed_q && !redirect_valid_i && (req_credit_i || pend_q);
    assign req_fire_o       = imem_req_valid_o && imem_req_ready_i;
    assign imem_req_o       = '{addr: addr_q};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            armed_q <= 1'b0;
            pend_q  <= 1'b0;
        end else begin
            if (redirect_valid_i) begin
                armed_q <= 1'b1;
            end
            pend_q <= imem_req_valid_o && !imem_req_ready_i;  // Dropped by a redirect
        end
    end

    // Word address of the next request
    always_ff @(posedge clk_i) begin
        if (redirect_valid_i) begin
            addr_q <= {redirect_i.pc[XLEN-1:2], 2'b00};  // Aligner skips the low parcel itself
        end else if (req_fire_o) begin
            addr_q <= addr_q + XLEN'(4);
        end
    end

    // A stalled request keeps its address until taken or cancelled by a redirect
    property p_req_hold;
        @(posedge clk_i) disable iff (!rstn_i)
        imem_req_valid_o && !imem_req_ready_i
        |=> redirect_valid_i || (imem_req_valid_o && $stable(imem_req_o.addr));
    endproperty

    a_req_hold : assert property (p_req_hold)
        else $error("fetch_req_gen: stalled request changed before it was taken");

endmodule

// File: logic/fetch_align.sv
`timescale 1ns/1ps

module fetch_align #(
    parameter int unsigned MAX_OUTSTANDING = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  logic                 redirect_valid_i,
    input  fetch_pkg::redirect_t redirect_i,

    input  logic                 req_fire_i,
    output logic                 req_credit_o,

    input  logic                 imem_rsp_valid_i,
    output logic                 imem_rsp_ready_o,
    input  fetch_pkg::imem_rsp_t imem_rsp_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output fetch_pkg::instr_t    out_instr_o
);

    localparam int XLEN  = isa_pkg::XLEN;
    localparam int PW    = isa_pkg::PARCEL_W;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    fetch_pkg::align_state_e state_q, state_d;

    logic [CNT_W-1:0] outst_q, outst_d;        // Requests without a response yet
    logic [CNT_W-1:0] discard_q, discard_d;    // Of those, the ones from the old path
    logic             first_q, first_d;        // Next word is the first after a redirect
    logic [XLEN-1:0]  word_pc_q, word_pc_d;    // Pc of the next word to arrive
    logic [PW-1:0]    half_q, half_d;
    logic [XLEN-1:0]  half_pc_q, half_pc_d;
    logic             out_valid_q, out_valid_d;
    fetch_pkg::instr_t out_instr_q, out_instr_d;

    logic             out_free;
    logic             rsp_fire;
    logic             emit;
    logic             skip_lo;
    logic [XLEN-1:0]  word_base;
    logic [PW-1:0]    lo, hi;
    isa_pkg::ilen_e   lo_len, hi_len, half_len;

    assign lo        = imem_rsp_i.data[PW-1:0];
    assign hi        = imem_rsp_i.data[XLEN-1:PW];
    assign lo_len    = isa_pkg::parcel_len(lo);
    assign hi_len    = isa_pkg::parcel_len(hi);
    assign half_len  = isa_pkg::parcel_len(half_q);
    assign word_base = {word_pc_q[XLEN-1:2], 2'b00};
    assign skip_lo   = first_q && word_pc_q[1];  // Execution starts in the upper parcel

    assign out_free     = !out_valid_q || out_ready_i;
    assign req_credit_o = outst_q < CNT_W'(MAX_OUTSTANDING);

    // A compressed held parcel goes out on its own, so no word is taken then
    always_comb begin
        unique case (state_q)
            fetch_pkg::ALIGN_EMPTY: imem_rsp_ready_o = out_free;
            fetch_pkg::ALIGN_HALF:  imem_rsp_ready_o = out_free && (half_len == isa_pkg::ILEN_32);
            fetch_pkg::ALIGN_DRAIN: imem_rsp_ready_o = 1'b1;
            default:                imem_rsp_ready_o = 1'b0;
        endcase
    end

    assign rsp_fire = imem_rsp_valid_i && imem_rsp_ready_o;

    always_comb begin
        state_d     = state_q;
        discard_d   = discard_q;
        first_d     = first_q;
        word_pc_d   = word_pc_q;
        half_d      = half_q;
        half_pc_d   = half_pc_q;
        out_instr_d = out_instr_q;
        emit        = 1'b0;

        unique case (state_q)
            fetch_pkg::ALIGN_EMPTY: begin
                if (rsp_fire) begin
                    first_d   = 1'b0;
                    word_pc_d = word_base + XLEN'(4);
                    if (skip_lo && hi_len == isa_pkg::ILEN_32) begin
                        half_d    = hi;  // Lone upper parcel opens a 32-bit instruction
                        half_pc_d = word_base + XLEN'(2);
                        state_d   = fetch_pkg::ALIGN_HALF;
                    end else if (skip_lo) begin
                        emit        = 1'b1;
                        out_instr_d = '{bits: {{(XLEN-PW){1'b0}}, hi},
                                        pc: word_base + XLEN'(2), len: isa_pkg::ILEN_16};
                    end else if (lo_len == isa_pkg::ILEN_32) begin
                        emit        = 1'b1;
                        out_instr_d = '{bits: {hi, lo}, pc: word_base, len: isa_pkg::ILEN_32};
                    end else begin
                        emit        = 1'b1;
                        out_instr_d = '{bits: {{(XLEN-PW){1'b0}}, lo},
                                        pc: word_base, len: isa_pkg::ILEN_16};
                        half_d      = hi;
                        half_pc_d   = word_base + XLEN'(2);
                        state_d     = fetch_pkg::ALIGN_HALF;
                    end
                end
            end
            fetch_pkg::ALIGN_HALF: begin
                if (half_len == isa_pkg::ILEN_16) begin
                    if (out_free) begin
                        emit        = 1'b1;
                        out_instr_d = '{bits: {{(XLEN-PW){1'b0}}, half_q},
                                        pc: half_pc_q, len: isa_pkg::ILEN_16};
                        state_d     = fetch_pkg::ALIGN_EMPTY;
                    end
                end else if (rsp_fire) begin
                    // Held parcel is the low half of an instruction crossing the word edge
                    emit        = 1'b1;
                    out_instr_d = '{bits: {lo, half_q}, pc: half_pc_q, len: isa_pkg::ILEN_32};
                    half_d      = hi;
                    half_pc_d   = word_base + XLEN'(2);
                    word_pc_d   = word_base + XLEN'(4);
                end
            end
            fetch_pkg::ALIGN_DRAIN: begin
                if (rsp_fire) begin
                    discard_d = discard_q - CNT_W'(1);
                    if (discard_q == CNT_W'(1)) begin
                        state_d = fetch_pkg::ALIGN_EMPTY;
                    end
                end
            end
            default: state_d = fetch_pkg::ALIGN_EMPTY;
        endcase

        outst_d     = outst_q + CNT_W'(req_fire_i) - CNT_W'(rsp_fire);
        out_valid_d = emit || (out_valid_q && !out_ready_i);

        // Whatever is held or accepted in this cycle belongs to the old path
        if (redirect_valid_i) begin
            out_valid_d = 1'b0;
            first_d     = 1'b1;
            word_pc_d   = {redirect_i.pc[XLEN-1:1], 1'b0};
            discard_d   = outst_q - CNT_W'(rsp_fire);
            state_d     = (discard_d != '0) ? fetch_pkg::ALIGN_DRAIN : fetch_pkg::ALIGN_EMPTY;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= fetch_pkg::ALIGN_EMPTY;
            outst_q     <= '0;
            discard_q   <= '0;
            first_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            outst_q     <= outst_d;
            discard_q   <= discard_d;
            first_q     <= first_d;
            out_valid_q <= out_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        word_pc_q   <= word_pc_d;
        half_q      <= half_d;
        half_pc_q   <= half_pc_d;
        out_instr_q <= out_instr_d;
    end

    assign out_valid_o = out_valid_q;
    assign out_instr_o = out_instr_q;

    // The memory never answers more than was asked, and credit caps the count
    a_cnt_range : assert property (@(posedge clk_i) disable iff (!rstn_i)
        outst_q <= CNT_W'(MAX_OUTSTANDING) && discard_q <= outst_q)
        else $error("fetch_align: outstanding or discard counter out of range");

    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_fire |-> outst_q != '0)
        else $error("fetch_align: response accepted with nothing outstanding");

    a_out_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_o && !out_ready_i && !redirect_valid_i
        |=> out_valid_o && $stable(out_instr_o))
        else $error("fetch_align: output changed under back-pressure");

    a_pc_even : assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_o |-> out_instr_o.pc[0] == 1'b0)
        else $error("fetch_align: odd pc on output");

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int unsigned MAX_OUTSTANDING = 4  // Requests in flight toward the memory
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  logic                 redirect_valid_i,
    input  fetch_pkg::redirect_t redirect_i,

    output logic                 imem_req_valid_o,
    input  logic                 imem_req_ready_i,
    output fetch_pkg::imem_req_t imem_req_o,

    input  logic                 imem_rsp_valid_i,
    output logic                 imem_rsp_ready_o,
    input  fetch_pkg::imem_rsp_t imem_rsp_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output fetch_pkg::instr_t    out_instr_o
);

    logic req_fire;
    logic req_credit;

    fetch_req_gen i_fetch_req_gen (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_i       (redirect_i),
        .req_credit_i     (req_credit),
        .req_fire_o       (req_fire),
        .imem_req_valid_o (imem_req_valid_o),
        .imem_req_ready_i (imem_req_ready_i),
        .imem_req_o       (imem_req_o)
    );

    // Owns the outstanding count, so the credit comes back from here
    fetch_align #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_fetch_align (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_i       (redirect_i),
        .req_fire_i       (req_fire),
        .req_credit_o     (req_credit),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_ready_o (imem_rsp_ready_o),
        .imem_rsp_i       (imem_rsp_i),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_instr_o      (out_instr_o)
    );

endmodule

// File: tests/tb_imem_model.sv
`timescale 1ns/1ps

module tb_imem_model #(
    parameter int WORDS = 1024
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  fetch_pkg::imem_req_t req_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output fetch_pkg::imem_rsp_t rsp_o
);

    localparam int AW = $clog2(WORDS);

    logic [31:0] image [WORDS];  // Program image, written by the testbench
    logic [31:0] data_q [$];     // Words still owed, oldest first
    int          due_q [$];      // Cycle after which each owed word may be shown
    int          now = 0;

    // Words change hands on the rising edge
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            data_q.delete();
            due_q.delete();
            now = 0;
        end else begin
            if (rsp_valid_o && rsp_ready_i) begin
                void'(data_q.pop_front());
                void'(due_q.pop_front());
            end
            if (req_valid_i && req_ready_o) begin
                data_q.push_back(image[req_i.addr[AW+1:2]]);
                due_q.push_back(now + int'($urandom % 4));  // Zero to three extra cycles
            end
            now = now + 1;
        end
    end

    initial begin
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_o       = '0;
        forever begin
            @(negedge clk_i);
            req_ready_o = rstn_i && (($urandom % 4) != 0);  // Withheld about one cycle in four
            // The head word stays up until it is taken
            if (rstn_i && data_q.size() > 0 && due_q[0] < now) begin
                rsp_valid_o = 1'b1;
                rsp_o       = '{data: data_q[0]};
            end else begin
                rsp_valid_o = 1'b0;
                rsp_o       = '0;
            end
        end
    end

endmodule

// File: tests/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int MAX_OUTSTANDING = 4;
    localparam int IMEM_WORDS      = 1024;
    localparam int IMEM_AW         = $clog2(IMEM_WORDS);

    // Instructions checked per test
    localparam int N_ALIGNED   = 16;
    localparam int N_MIXED     = 24;
    localparam int N_SKIP      = 8;   // Per target, two targets
    localparam int N_FLUSH     = 16;
    localparam int N_STALL     = 24;
    localparam int TOTAL_INSTR = N_ALIGNED + N_MIXED + 2 * N_SKIP + N_FLUSH + N_STALL;
    localparam int CYCLE_LIMIT = 40 * TOTAL_INSTR;

    // Bit i set makes instruction i of a mixed stream a 32-bit one
    localparam logic [9:0] MIX_PATTERN = 10'b10_0011_0100;

    logic                 clk;
    logic                 rstn;
    logic                 redirect_valid;
    fetch_pkg::redirect_t redirect;
    logic                 imem_req_valid, imem_req_ready;
    fetch_pkg::imem_req_t imem_req;
    logic                 imem_rsp_valid, imem_rsp_ready;
    fetch_pkg::imem_rsp_t imem_rsp;
    logic                 out_valid, out_ready;
    fetch_pkg::instr_t    out_instr;

    fetch_pkg::instr_t    expected_q [$];
    int                   errors = 0;
    int                   checks = 0;
    int                   tests_run = 0;
    int                   cycle_cnt = 0;
    int                   redirect_cycle = 0;

    fetch_top #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_fetch_top (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .redirect_valid_i (redirect_valid),
        .redirect_i       (redirect),
        .imem_req_valid_o (imem_req_valid),
        .imem_req_ready_i (imem_req_ready),
        .imem_req_o       (imem_req),
        .imem_rsp_valid_i (imem_rsp_valid),
        .imem_rsp_ready_o (imem_rsp_ready),
        .imem_rsp_i       (imem_rsp),
        .out_valid_o      (out_valid),
        .out_ready_i      (out_ready),
        .out_instr_o      (out_instr)
    );

    tb_imem_model #(
        .WORDS (IMEM_WORDS)
    ) i_imem_model (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_valid_i (imem_req_valid),
        .req_ready_o (imem_req_ready),
        .req_i       (imem_req),
        .rsp_valid_o (imem_rsp_valid),
        .rsp_ready_i (imem_rsp_ready),
        .rsp_o       (imem_rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the expected instructions did not arrive in %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [15:0] read_parcel(input logic [31:0] pc);
        logic [31:0] word;
        word = i_imem_model.image[pc[IMEM_AW+1:2]];
        return pc[1] ? word[31:16] : word[15:0];
    endfunction

    task automatic write_parcel(input logic [31:0] pc, input logic [15:0] parcel);
        logic [31:0] word;
        word = i_imem_model.image[pc[IMEM_AW+1:2]];
        if (pc[1]) begin
            word[31:16] = parcel;
        end else begin
            word[15:0] = parcel;
        end
        i_imem_model.image[pc[IMEM_AW+1:2]] = word;
    endtask

    // Random instruction bits, only the length code of each first parcel is chosen
    task automatic place_program(input logic [31:0] start_pc, input int count, input bit mixed);
        logic [31:0] pc;
        logic [15:0] parcel;
        pc = start_pc;
        for (int n = 0; n < count; n++) begin
            parcel = 16'($urandom);
            if (!mixed || MIX_PATTERN[n % 10]) begin
                parcel[1:0] = 2'b11;
                write_parcel(pc, parcel);
                write_parcel(pc + 32'd2, 16'($urandom));
                pc = pc + 32'd4;
            end else begin
                parcel[1:0] = 2'($urandom % 3);
                write_parcel(pc, parcel);
                pc = pc + 32'd2;
            end
        end
    endtask

    // Walks the image parcel by parcel the way decode expects to see it
    task automatic build_expected(input logic [31:0] start_pc, input int count);
        fetch_pkg::instr_t item;
        logic [31:0]       pc;
        logic [15:0]       first;
        expected_q.delete();
        pc = start_pc;
        for (int n = 0; n < count; n++) begin
            first   = read_parcel(pc);
            item.pc = pc;
            if (first[1:0] == 2'b11) begin
                item.bits = {read_parcel(pc + 32'd2), first};
                item.len  = isa_pkg::ILEN_32;
                pc        = pc + 32'd4;
            end else begin
                item.bits = {16'h0000, first};
                item.len  = isa_pkg::ILEN_16;
                pc        = pc + 32'd2;
            end
            expected_q.push_back(item);
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect       = '{pc: target};
        @(posedge clk);
        redirect_cycle = cycle_cnt;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic collect_stream(input int count, input bit random_ready);
        fetch_pkg::instr_t exp;
        int                received;
        int                first_cycle;
        received    = 0;
        first_cycle = -1;
        while (received < count) begin
            @(negedge clk);
            out_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
            @(posedge clk);
            if (out_valid && first_cycle < 0) begin
                first_cycle = cycle_cnt;
            end
            if (out_valid && out_ready) begin
                exp = expected_q.pop_front();
                compare_value("out_instr.pc", out_instr.pc, exp.pc);
                compare_value("out_instr.bits", out_instr.bits, exp.bits);
                compare_value("out_instr.len", 32'(out_instr.len), 32'(exp.len));
                received++;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
        // Request, response and output register each need a cycle after the redirect
        compare_value("redirect_latency_ok", 32'(first_cycle - redirect_cycle >= 3), 32'd1);
    endtask

    task automatic run_stream(input logic [31:0] target, input int count, input bit mixed,
                              input bit random_ready);
        place_program(target, count, mixed);
        build_expected(target, count);
        send_redirect(target);
        collect_stream(count, random_ready);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("%-32s %s, %0d errors", name,
                 (errors == err_before) ? "ok" : "mismatch", errors - err_before);
    endtask

    task automatic test_aligned_stream();
        int err_before;
        err_before = errors;
        run_stream(32'h040, N_ALIGNED, 1'b0, 1'b0);
        report_test("aligned 32-bit stream", err_before);
    endtask

    task automatic test_mixed_stream();
        int err_before;
        err_before = errors;
        run_stream(32'h100, N_MIXED, 1'b1, 1'b0);  // Starts with two compressed in one word
        report_test("mixed stream", err_before);
    endtask

    task automatic test_odd_target();
        int err_before;
        err_before = errors;
        // The skipped parcels would open 32-bit instructions if they were used
        write_parcel(32'h200, 16'hffff);
        write_parcel(32'h300, 16'hffff);
        run_stream(32'h202, N_SKIP, 1'b1, 1'b0);  // Compressed in the upper half
        run_stream(32'h302, N_SKIP, 1'b0, 1'b0);  // 32-bit that opens in the upper half
        report_test("odd target skips low parcel", err_before);
    endtask

    task automatic test_redirect_in_flight();
        int err_before;
        int fires;
        err_before = errors;
        fires      = 0;
        place_program(32'h400, N_FLUSH, 1'b0);
        place_program(32'h500, N_FLUSH, 1'b1);
        send_redirect(32'h400);
        // Decode stalls so old-path words pile up in the memory and the output register
        while (!(out_valid && fires >= 3)) begin
            @(posedge clk);
            if (imem_req_valid && imem_req_ready) begin
                fires++;
            end
        end
        build_expected(32'h500, N_FLUSH);
        send_redirect(32'h500);
        collect_stream(N_FLUSH, 1'b0);
        report_test("redirect with requests in flight", err_before);
    endtask

    task automatic test_output_stall();
        int err_before;
        err_before = errors;
        run_stream(32'h600, N_STALL, 1'b1, 1'b1);
        report_test("random decode back-pressure", err_before);
    endtask

    initial begin
        void'($urandom(32'h4de83dfc));
        rstn           = 1'b0;
        redirect_valid = 1'b0;
        redirect       = '0;
        out_ready      = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            i_imem_model.image[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        end
        repeat (4) @(negedge clk);
        rstn = 1'b1;

        test_aligned_stream();
        test_mixed_stream();
        test_odd_target();
        test_redirect_in_flight();
        test_output_stall();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_req_gen.sv
logic/fetch_align.sv
logic/fetch_top.sv
tests/tb_imem_model.sv
tests/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  # Packages come first, the RTL top level last
  - files:
      - logic/isa_pkg.sv
      - logic/fetch_pkg.sv
      - logic/fetch_req_gen.sv
      - logic/fetch_align.sv
      - logic/fetch_top.sv

  # Testbench with its memory model, top module tb_fetch_top
  - target: test
    files:
      - tests/tb_imem_model.sv
      - tests/tb_fetch_top.sv
